/* run.sh */
#!/usr/bin/env bash
# build and run the fetch front testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f \
    --top-module tb_fetch_front -o sim_fetch_front

output=$(./obj_dir/sim_fetch_front 2>&1 || true)
echo "$output"

if echo "$output" | grep -qx 'All tests passed!'; then
    exit 0
else
    exit 1
fi

/* sim/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;    // 8 ns period
    end

    // release just after an edge, like the rest of the stimulus
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* sim/tb_fetch_front.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_front;
    import fetch_pkg::*;

    localparam int   BTB_N   = 16;
    localparam int   TLB_N   = 8;
    localparam u32_t P_HIT   = 32'h1c000100;
    localparam u32_t P_TGT   = 32'h1c000800;
    localparam u32_t P_ALIAS = 32'h1c000140;  // same btb index, other tag

    logic        clk;
    logic        rst_n;
    wr_pc_req_t  if2_req;
    wr_pc_req_t  ex_req;
    wr_pc_req_t  excp_req;
    logic        flush;
    logic        next_rdy;
    logic        icache_busy;
    logic        btb_update_valid;
    u32_t        btb_update_pc;
    u32_t        btb_update_target;
    crmd_t       crmd;
    dmw_t        dmw0;
    dmw_t        dmw1;
    logic        tlb_we;
    logic [2:0]  tlb_widx;
    tlb_entry_t  tlb_wentry;
    logic        rdy_in;
    fetch_pass_t pass_out;
    excp_pass_t  excp_pass_out;
    ic_op_t      icache_op;
    logic [11:0] icache_idx;
    u32_t        icache_pa;
    logic        icache_is_cached;

    // reference model state
    u32_t        m_pc;
    logic [15:0] sb_valid;
    logic [25:0] sb_tag [BTB_N];
    u32_t        sb_target [BTB_N];
    logic        m_pred_valid;
    u32_t        m_pred_npc;
    tlb_entry_t  st [TLB_N];

    // reference model outputs
    logic        m_stall;
    logic        m_rdy;
    logic        m_redir;
    logic        m_valid;
    u32_t        m_npc;
    logic        m_is_pred;
    ic_op_t      m_op;
    u32_t        m_pa;
    logic [1:0]  m_mat;
    logic        m_use_tlb;
    logic        m_tlb_hit;
    tlb_entry_t  m_entry;
    excp_pass_t  m_excp;
    logic        m_check_pa;

    int unsigned seed_ret;
    int          errors;

    tb_clock #(.RESET_CYCLES(10)) clkgen (.clk(clk), .rst_n(rst_n));

    fetch_front #(
        .BTB_ENTRIES   (BTB_N),
        .TLB_ENTRY_NUM (TLB_N)
    ) dut0 (
        .clk (clk), .rst_n (rst_n),
        .if2_wr_pc_req (if2_req), .ex_wr_pc_req (ex_req), .excp_wr_pc_req (excp_req),
        .flush (flush), .next_rdy (next_rdy), .rdy_in (rdy_in),
        .pass_out (pass_out), .excp_pass_out (excp_pass_out),
        .icache_op (icache_op), .icache_idx (icache_idx), .icache_pa (icache_pa),
        .icache_is_cached (icache_is_cached), .icache_busy (icache_busy),
        .btb_update_valid (btb_update_valid), .btb_update_pc (btb_update_pc),
        .btb_update_target (btb_update_target),
        .crmd (crmd), .dmw0 (dmw0), .dmw1 (dmw1),
        .tlb_we (tlb_we), .tlb_widx (tlb_widx), .tlb_wentry (tlb_wentry)
    );

    // next pc by priority excp, ex, if2, btb, pc + 4
    always_comb begin
        m_stall   = !next_rdy || icache_busy;
        m_rdy     = flush || !m_stall;
        m_redir   = excp_req.valid || ex_req.valid || if2_req.valid;
        m_valid   = !flush && !m_stall;
        m_op      = flush ? IC_NOP : IC_R;
        m_is_pred = !m_redir;
        if (excp_req.valid) m_npc = excp_req.pc;
        else if (ex_req.valid) m_npc = ex_req.pc;
        else if (if2_req.valid) m_npc = if2_req.pc;
        else if (m_pred_valid) m_npc = m_pred_npc;
        else m_npc = m_pc + 32'd4;
    end

    // expected translation of the held pc
    always_comb begin
        m_use_tlb = 1'b0;
        m_tlb_hit = 1'b0;
        m_entry   = '0;
        if (crmd.da) begin
            m_pa  = m_pc;
            m_mat = crmd.datf;
        end else if (crmd.pg && (dmw0.plv0 || dmw0.plv3) && dmw0.vseg == m_pc[31:29]) begin
            m_pa  = {dmw0.pseg, m_pc[28:0]};
            m_mat = dmw0.mat;
        end else if (crmd.pg && (dmw1.plv0 || dmw1.plv3) && dmw1.vseg == m_pc[31:29]) begin
            m_pa  = {dmw1.pseg, m_pc[28:0]};
            m_mat = dmw1.mat;
        end else begin
            m_use_tlb = 1'b1;
            for (int i = 0; i < TLB_N; i++) begin
                if (!m_tlb_hit && st[i].e && st[i].vppn == m_pc[31:13]) begin
                    m_tlb_hit = 1'b1;
                    m_entry   = st[i];
                end
            end
            m_pa  = {m_entry.ppn, m_pc[11:0]};
            m_mat = m_entry.mat;
        end
        m_excp.valid          = 1'b0;
        m_excp.esubcode_ecode = '0;
        m_excp.badv           = m_pc;
        if (!flush && m_pc[1:0] != 2'b00) begin
            m_excp.valid          = 1'b1;
            m_excp.esubcode_ecode = ECODE_ADEF;
        end else if (!flush && m_use_tlb && !m_tlb_hit) begin
            m_excp.valid          = 1'b1;
            m_excp.esubcode_ecode = ECODE_TLBR;
        end else if (!flush && m_use_tlb && !m_entry.v) begin
            m_excp.valid          = 1'b1;
            m_excp.esubcode_ecode = ECODE_PIF;
        end
        m_check_pa = !flush && !m_excp.valid;  // pa is a don't care otherwise
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            m_pc         <= RESET_PC;
            sb_valid     <= '0;
            m_pred_valid <= 1'b0;
            for (int i = 0; i < TLB_N; i++) st[i] <= '0;
        end else begin
            if (btb_update_valid) begin
                sb_valid[btb_update_pc[5:2]]  <= 1'b1;
                sb_tag[btb_update_pc[5:2]]    <= btb_update_pc[31:6];
                sb_target[btb_update_pc[5:2]] <= btb_update_target;
            end
            if (m_rdy || m_redir) begin   // redirects load even when stalled
                m_pc         <= m_npc;
                m_pred_valid <= sb_valid[m_npc[5:2]] && sb_tag[m_npc[5:2]] == m_npc[31:6];
                m_pred_npc   <= sb_target[m_npc[5:2]];
            end
            if (tlb_we) st[tlb_widx] <= tlb_wentry;
        end
    end

    chk_valid: assert property (@(negedge clk) !rst_n || pass_out.valid == m_valid)
        else report_mismatch("pass_out.valid", 64'(pass_out.valid), 64'(m_valid));
    chk_pc: assert property (@(negedge clk) !rst_n || pass_out.pc == m_pc)
        else report_mismatch("pass_out.pc", 64'(pass_out.pc), 64'(m_pc));
    chk_btb_pre: assert property (@(negedge clk) !rst_n || pass_out.btb_pre == m_npc)
        else report_mismatch("pass_out.btb_pre", 64'(pass_out.btb_pre), 64'(m_npc));
    chk_is_pred: assert property (@(negedge clk) !rst_n || pass_out.is_pred == m_is_pred)
        else report_mismatch("pass_out.is_pred", 64'(pass_out.is_pred), 64'(m_is_pred));
    chk_rdy: assert property (@(negedge clk) !rst_n || rdy_in == m_rdy)
        else report_mismatch("rdy_in", 64'(rdy_in), 64'(m_rdy));
    chk_op: assert property (@(negedge clk) !rst_n || icache_op == m_op)
        else report_mismatch("icache_op", 64'(icache_op), 64'(m_op));
    chk_idx: assert property (@(negedge clk) !rst_n || icache_idx == m_pc[11:0])
        else report_mismatch("icache_idx", 64'(icache_idx), 64'(m_pc[11:0]));
    chk_pa: assert property (@(negedge clk) !rst_n || !m_check_pa || icache_pa == m_pa)
        else report_mismatch("icache_pa", 64'(icache_pa), 64'(m_pa));
    chk_cached: assert property (@(negedge clk)
            !rst_n || !m_check_pa || icache_is_cached == m_mat[0])
        else report_mismatch("icache_is_cached", 64'(icache_is_cached), 64'(m_mat[0]));
    chk_excp: assert property (@(negedge clk) !rst_n || excp_pass_out == m_excp)
        else report_mismatch("excp_pass_out", 64'(excp_pass_out), 64'(m_excp));

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        errors++;
        $display("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp);
        stop_with_failure("first error reached");
    endtask

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    function automatic wr_pc_req_t make_req(input logic v, input u32_t pc);
        make_req.valid = v;
        make_req.pc    = pc;
    endfunction

    // one-cycle strobes on all three redirect inputs
    task automatic send_redirects(input wr_pc_req_t xc, input wr_pc_req_t ex,
                                  input wr_pc_req_t i2);
        excp_req = xc;
        ex_req   = ex;
        if2_req  = i2;
        step();
        excp_req = '0;
        ex_req   = '0;
        if2_req  = '0;
    endtask

    task automatic jump_to(input u32_t pc);
        send_redirects('0, '0, make_req(1'b1, pc));
    endtask

    task automatic wait_for_pc(input u32_t target, input int limit);
        int n;
        n = 0;
        @(negedge clk);
        while (!(pass_out.valid && pass_out.pc == target)) begin
            n++;
            if (n > limit) stop_with_failure($sformatf("timeout waiting for pc %08h", target));
            else @(negedge clk);
        end
    endtask

    task automatic wait_for_excp(input ecode_t code, input u32_t va, input int limit);
        int n;
        n = 0;
        @(negedge clk);
        while (!excp_pass_out.valid) begin
            n++;
            if (n > limit) stop_with_failure("timeout waiting for a fetch exception");
            else @(negedge clk);
        end
        assert (excp_pass_out.esubcode_ecode == code)
            else report_mismatch("excp_pass_out.esubcode_ecode",
                                 64'(excp_pass_out.esubcode_ecode), 64'(code));
        assert (excp_pass_out.badv == va)
            else report_mismatch("excp_pass_out.badv", 64'(excp_pass_out.badv), 64'(va));
    endtask

    task automatic wait_reset_done(input int limit);
        int n;
        n = 0;
        @(negedge clk);
        while (!rst_n) begin
            n++;
            if (n > limit) stop_with_failure("reset was never released");
            else @(negedge clk);
        end
    endtask

    initial begin
        seed_ret          = $urandom(32'h470e_4042);
        errors            = 0;
        if2_req           = '0;
        ex_req            = '0;
        excp_req          = '0;
        flush             = 1'b0;
        next_rdy          = 1'b1;
        icache_busy       = 1'b0;
        btb_update_valid  = 1'b0;
        btb_update_pc     = '0;
        btb_update_target = '0;
        crmd              = '{da: 1'b1, pg: 1'b0, datf: 2'b01};
        dmw0              = '0;
        dmw1              = '0;
        tlb_we            = 1'b0;
        tlb_widx          = '0;
        tlb_wentry        = '0;

        wait_reset_done(20);
        assert (pass_out.valid && pass_out.pc == RESET_PC)
            else report_mismatch("pass_out.pc", 64'(pass_out.pc), 64'(RESET_PC));
        step();
        run_cycles(8);                                 // sequential fetch

        send_redirects(make_req(1'b1, 32'h1c001000), make_req(1'b1, 32'h1c002000),
                       make_req(1'b1, 32'h1c003000));
        wait_for_pc(32'h1c001000, 2);
        step();
        next_rdy = 1'b0;                               // redirect under back-pressure
        send_redirects('0, make_req(1'b1, 32'h1c002000), make_req(1'b1, 32'h1c003000));
        next_rdy = 1'b1;
        wait_for_pc(32'h1c002000, 2);
        step();

        btb_update_valid  = 1'b1;
        btb_update_pc     = P_HIT;
        btb_update_target = P_TGT;
        step();
        btb_update_valid  = 1'b0;
        run_cycles(2);
        jump_to(P_HIT - 32'd8);
        wait_for_pc(P_HIT, 6);
        assert (pass_out.btb_pre == P_TGT)
            else report_mismatch("pass_out.btb_pre", 64'(pass_out.btb_pre), 64'(P_TGT));
        step();
        wait_for_pc(P_TGT, 2);
        step();
        jump_to(P_ALIAS);
        wait_for_pc(P_ALIAS, 3);
        assert (pass_out.btb_pre == P_ALIAS + 32'd4)
            else report_mismatch("pass_out.btb_pre", 64'(pass_out.btb_pre),
                                 64'(P_ALIAS + 32'd4));
        step();

        next_rdy = 1'b0;
        run_cycles(3);                                 // pc holds
        next_rdy    = 1'b1;
        icache_busy = 1'b1;
        run_cycles(2);
        flush = 1'b1;                                  // flush overrides busy
        run_cycles(2);
        flush       = 1'b0;
        icache_busy = 1'b0;
        for (int k = 0; k < 80; k++) begin
            next_rdy    = ($urandom % 4) != 0;
            icache_busy = ($urandom % 5) == 0;
            flush       = ($urandom % 10) == 0;
            step();
        end
        next_rdy    = 1'b1;
        icache_busy = 1'b0;
        flush       = 1'b0;

        crmd.datf = 2'b00;                             // uncached direct mode
        run_cycles(3);
        jump_to(32'h1c000200);
        crmd = '{da: 1'b0, pg: 1'b1, datf: 2'b00};
        dmw0 = '{plv0: 1'b1, plv3: 1'b0, mat: 2'b01, pseg: 3'b101, vseg: 3'b000};
        run_cycles(3);
        dmw0 = '0;
        dmw1 = '{plv0: 1'b0, plv3: 1'b1, mat: 2'b00, pseg: 3'b010, vseg: 3'b000};
        run_cycles(3);
        crmd.pg = 1'b0;                                // window ignored, tlb path
        run_cycles(2);
        crmd.pg = 1'b1;

        tlb_we     = 1'b1;
        tlb_widx   = 3'd2;
        tlb_wentry = '{e: 1'b1, vppn: 19'h00201, ppn: 20'h8a5c3, v: 1'b1, mat: 2'b01};
        step();
        tlb_widx   = 3'd5;
        tlb_wentry = '{e: 1'b1, vppn: 19'h00500, ppn: 20'h12345, v: 1'b0, mat: 2'b01};
        step();
        tlb_we = 1'b0;
        dmw1   = '0;
        jump_to(32'h00402000);                         // tlb hit page
        run_cycles(4);
        jump_to(32'h00800000);
        wait_for_excp(ECODE_TLBR, 32'h00800000, 2);
        step();
        jump_to(32'h00a00000);
        wait_for_excp(ECODE_PIF, 32'h00a00000, 2);
        step();
        crmd.da = 1'b1;
        jump_to(32'h1c000002);                         // misaligned target
        wait_for_excp(ECODE_ADEF, 32'h1c000002, 2);
        step();
        jump_to(RESET_PC);
        run_cycles(4);

        if (errors == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            stop_with_failure("errors were recorded");
        end
    end

    task automatic run_cycles(input int n);
        repeat (n) step();
    endtask

endmodule

`default_nettype wire

/* src/addr_trans.sv */
`timescale 1ns/1ps
`default_nettype none

module addr_trans #(
    parameter int TLB_ENTRY_NUM = 8
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             en,
    input  fetch_pkg::u32_t                  va,
    input  fetch_pkg::crmd_t                 crmd,
    input  fetch_pkg::dmw_t                  dmw0,
    input  fetch_pkg::dmw_t                  dmw1,
    input  logic                             tlb_we,
    input  logic [$clog2(TLB_ENTRY_NUM)-1:0] tlb_widx,
    input  fetch_pkg::tlb_entry_t            tlb_wentry,
    output fetch_pkg::u32_t                  pa,
    output logic [1:0]                       mat,
    output fetch_pkg::excp_pass_t            excp
);
    import fetch_pkg::*;

    tlb_entry_t tlb [TLB_ENTRY_NUM];

    logic       dmw0_hit;
    logic       dmw1_hit;
    logic       tlb_hit;
    tlb_entry_t hit_entry;
    logic       use_tlb;

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < TLB_ENTRY_NUM; i++) begin
                tlb[i] <= '0;
            end
        end else if (tlb_we) begin
            tlb[tlb_widx] <= tlb_wentry;
        end
    end

    // windows only map in paged mode
    // a window with no privilege level enabled is switched off
    assign dmw0_hit = crmd.pg && (dmw0.plv0 | dmw0.plv3) && (dmw0.vseg == va[31:29]);
    assign dmw1_hit = crmd.pg && (dmw1.plv0 | dmw1.plv3) && (dmw1.vseg == va[31:29]);

    // fully associative match on va[31:13], lowest index wins
    always_comb begin
        tlb_hit   = 1'b0;
        hit_entry = '0;
        for (int i = TLB_ENTRY_NUM - 1; i >= 0; i--) begin
            if (tlb[i].e && (tlb[i].vppn == va[31:13])) begin
                tlb_hit   = 1'b1;
                hit_entry = tlb[i];
            end
        end
    end

    assign use_tlb = !crmd.da && !dmw0_hit && !dmw1_hit;

    always_comb begin
        if (crmd.da) begin
            pa  = va;
            mat = crmd.datf;
        end else if (dmw0_hit) begin
            pa  = {dmw0.pseg, va[28:0]};
            mat = dmw0.mat;
        end else if (dmw1_hit) begin
            pa  = {dmw1.pseg, va[28:0]};
            mat = dmw1.mat;
        end else begin
            pa  = {hit_entry.ppn, va[11:0]};  // zero page on a miss
            mat = hit_entry.mat;
        end
    end

    always_comb begin
        excp.valid          = 1'b0;
        excp.esubcode_ecode = '0;
        excp.badv           = va;
        if (en) begin
            if (va[1:0] != 2'b00) begin       // alignment fault beats tlb faults
                excp.valid          = 1'b1;
                excp.esubcode_ecode = ECODE_ADEF;
            end else if (use_tlb && !tlb_hit) begin
                excp.valid          = 1'b1;
                excp.esubcode_ecode = ECODE_TLBR;
            end else if (use_tlb && !hit_entry.v) begin
                excp.valid          = 1'b1;
                excp.esubcode_ecode = ECODE_PIF;
            end
        end
    end

endmodule

`default_nettype wire

/* src/btb.sv */
`timescale 1ns/1ps
`default_nettype none

module btb #(
    parameter int BTB_ENTRIES = 16
) (
    input  logic           clk,
    input  logic           rst_n,
    btb_if.btb_side        port,
    input  logic           update_valid,
    input  fetch_pkg::u32_t update_pc,
    input  fetch_pkg::u32_t update_target
);
    import fetch_pkg::*;

    localparam int IDX_W = $clog2(BTB_ENTRIES);
    localparam int TAG_W = 32 - 2 - IDX_W;

    logic [BTB_ENTRIES-1:0] valid_r;
    logic [TAG_W-1:0]       tag_mem    [BTB_ENTRIES];
    u32_t                   target_mem [BTB_ENTRIES];

    logic [IDX_W-1:0] lk_idx;
    logic [TAG_W-1:0] lk_tag;
    logic [IDX_W-1:0] up_idx;
    logic [TAG_W-1:0] up_tag;
    logic             lk_hit;

    logic pred_valid_r;
    u32_t pred_npc_r;

    assign lk_idx = port.lookup_pc[IDX_W+1:2];
    assign lk_tag = port.lookup_pc[31:IDX_W+2];
    assign up_idx = update_pc[IDX_W+1:2];
    assign up_tag = update_pc[31:IDX_W+2];

    assign lk_hit = valid_r[lk_idx] && (tag_mem[lk_idx] == lk_tag);

    // valid bits and the hit flag are control state
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            valid_r      <= '0;
            pred_valid_r <= 1'b0;
        end else begin
            if (update_valid) begin
                valid_r[up_idx] <= 1'b1;
            end
            if (!port.stall) begin
                pred_valid_r <= lk_hit;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (update_valid) begin
            tag_mem[up_idx]    <= up_tag;
            target_mem[up_idx] <= update_target;
        end
        if (!port.stall) begin
            pred_npc_r <= target_mem[lk_idx];  // old entry if written at the same edge
        end
    end

    assign port.pred_valid = pred_valid_r;
    assign port.pred_npc   = pred_npc_r;

endmodule

`default_nettype wire

/* src/btb_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface btb_if;
    import fetch_pkg::*;

    u32_t lookup_pc;   // pc to predict for, sampled at the edge
    logic stall;       // hold the registered prediction
    logic pred_valid;  // btb hit for the current pc
    u32_t pred_npc;    // predicted target

    modport fetch_side (
        output lookup_pc,
        output stall,
        input  pred_valid,
        input  pred_npc
    );

    modport btb_side (
        input  lookup_pc,
        input  stall,
        output pred_valid,
        output pred_npc
    );

endinterface

`default_nettype wire

/* src/fetch1.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch1 (
    input  logic                   clk,
    input  logic                   rst_n,
    btb_if.fetch_side              btb,
    input  fetch_pkg::wr_pc_req_t  if2_wr_pc_req,
    input  fetch_pkg::wr_pc_req_t  ex_wr_pc_req,
    input  fetch_pkg::wr_pc_req_t  excp_wr_pc_req,
    input  logic                   flush,
    input  logic                   next_rdy,
    input  logic                   icache_busy,
    output logic                   rdy_in,
    output fetch_pkg::u32_t        fetch_va,
    output logic                   fetch_en,
    input  fetch_pkg::u32_t        pa,
    input  logic [1:0]             mat,
    input  fetch_pkg::excp_pass_t  addr_excp,
    output fetch_pkg::ic_op_t      icache_op,
    output logic [11:0]            icache_idx,
    output fetch_pkg::u32_t        icache_pa,
    output logic                   icache_is_cached,
    output fetch_pkg::fetch_pass_t pass_out,
    output fetch_pkg::excp_pass_t  excp_pass_out
);
    import fetch_pkg::*;

    u32_t pc_r;
    u32_t npc;
    logic is_pred;
    logic stall;
    logic redirect;
    logic pc_load;

    assign stall    = ~next_rdy | icache_busy;
    assign rdy_in   = flush | ~stall;           // flush overrides back-pressure
    assign redirect = excp_wr_pc_req.valid | ex_wr_pc_req.valid | if2_wr_pc_req.valid;
    assign pc_load  = rdy_in | redirect;        // redirects are never dropped

    // next pc, highest priority first
    always_comb begin
        if (excp_wr_pc_req.valid) begin
            npc     = excp_wr_pc_req.pc;
            is_pred = 1'b0;
        end else if (ex_wr_pc_req.valid) begin
            npc     = ex_wr_pc_req.pc;
            is_pred = 1'b0;
        end else if (if2_wr_pc_req.valid) begin
            npc     = if2_wr_pc_req.pc;
            is_pred = 1'b0;
        end else if (btb.pred_valid) begin
            npc     = btb.pred_npc;             // prediction made for the current pc_r
            is_pred = 1'b1;
        end else begin
            npc     = pc_r + 32'd4;
            is_pred = 1'b1;
        end
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            pc_r <= RESET_PC;
        end else if (pc_load) begin
            pc_r <= npc;
        end
    end

    // btb samples npc whenever pc_r takes it, so its output tracks pc_r
    assign btb.lookup_pc = npc;
    assign btb.stall     = ~pc_load;

    // translation of the held pc
    assign fetch_va = pc_r;
    assign fetch_en = ~flush;

    // icache request, reissued while held
    assign icache_op        = flush ? IC_NOP : IC_R;
    assign icache_idx       = pc_r[11:0];
    assign icache_pa        = pa;
    assign icache_is_cached = mat[0];

    assign pass_out.valid   = ~flush & ~stall;
    assign pass_out.pc      = pc_r;
    assign pass_out.btb_pre = npc;
    assign pass_out.is_pred = is_pred;

    // flush is resolved further down the pipe
    assign excp_pass_out = addr_excp;

endmodule

`default_nettype wire

/* src/fetch_front.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_front #(
    parameter int BTB_ENTRIES   = 16,
    parameter int TLB_ENTRY_NUM = 8
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  fetch_pkg::wr_pc_req_t            if2_wr_pc_req,
    input  fetch_pkg::wr_pc_req_t            ex_wr_pc_req,
    input  fetch_pkg::wr_pc_req_t            excp_wr_pc_req,
    input  logic                             flush,
    input  logic                             next_rdy,
    output logic                             rdy_in,
    output fetch_pkg::fetch_pass_t           pass_out,
    output fetch_pkg::excp_pass_t            excp_pass_out,
    output fetch_pkg::ic_op_t                icache_op,
    output logic [11:0]                      icache_idx,
    output fetch_pkg::u32_t                  icache_pa,
    output logic                             icache_is_cached,
    input  logic                             icache_busy,
    input  logic                             btb_update_valid,
    input  fetch_pkg::u32_t                  btb_update_pc,
    input  fetch_pkg::u32_t                  btb_update_target,
    input  fetch_pkg::crmd_t                 crmd,
    input  fetch_pkg::dmw_t                  dmw0,
    input  fetch_pkg::dmw_t                  dmw1,
    input  logic                             tlb_we,
    input  logic [$clog2(TLB_ENTRY_NUM)-1:0] tlb_widx,
    input  fetch_pkg::tlb_entry_t            tlb_wentry
);
    import fetch_pkg::*;

    u32_t       fetch_va;
    logic       fetch_en;
    u32_t       pa;
    logic [1:0] mat;
    excp_pass_t addr_excp;

    btb_if btb_bus ();

    fetch1 u_fetch1 (
        .clk              (clk),
        .rst_n            (rst_n),
        .btb              (btb_bus.fetch_side),
        .if2_wr_pc_req    (if2_wr_pc_req),
        .ex_wr_pc_req     (ex_wr_pc_req),
        .excp_wr_pc_req   (excp_wr_pc_req),
        .flush            (flush),
        .next_rdy         (next_rdy),
        .icache_busy      (icache_busy),
        .rdy_in           (rdy_in),
        .fetch_va         (fetch_va),
        .fetch_en         (fetch_en),
        .pa               (pa),
        .mat              (mat),
        .addr_excp        (addr_excp),
        .icache_op        (icache_op),
        .icache_idx       (icache_idx),
        .icache_pa        (icache_pa),
        .icache_is_cached (icache_is_cached),
        .pass_out         (pass_out),
        .excp_pass_out    (excp_pass_out)
    );

    btb #(
        .BTB_ENTRIES (BTB_ENTRIES)
    ) u_btb (
        .clk           (clk),
        .rst_n         (rst_n),
        .port          (btb_bus.btb_side),
        .update_valid  (btb_update_valid),
        .update_pc     (btb_update_pc),
        .update_target (btb_update_target)
    );

    addr_trans #(
        .TLB_ENTRY_NUM (TLB_ENTRY_NUM)
    ) u_addr_trans (
        .clk        (clk),
        .rst_n      (rst_n),
        .en         (fetch_en),
        .va         (fetch_va),
        .crmd       (crmd),
        .dmw0       (dmw0),
        .dmw1       (dmw1),
        .tlb_we     (tlb_we),
        .tlb_widx   (tlb_widx),
        .tlb_wentry (tlb_wentry),
        .pa         (pa),
        .mat        (mat),
        .excp       (addr_excp)
    );

endmodule

`default_nettype wire

/* src/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

    typedef logic [31:0] u32_t;

    // redirect request from a later stage
    typedef struct packed {
        logic valid;
        u32_t pc;
    } wr_pc_req_t;

    // instruction cache opcodes
    typedef enum logic [2:0] {
        IC_NOP = 3'd0,
        IC_R   = 3'd1
    } ic_op_t;

    // {esubcode[8:0], ecode[5:0]}
    typedef logic [14:0] ecode_t;

    localparam ecode_t ECODE_ADEF = {9'd0, 6'h08}; // fetch address error
    localparam ecode_t ECODE_TLBR = {9'd0, 6'h3f}; // tlb refill
    localparam ecode_t ECODE_PIF  = {9'd0, 6'h03}; // fetch page invalid

    typedef struct packed {
        logic   valid;
        ecode_t esubcode_ecode;
        u32_t   badv;
    } excp_pass_t;

    // fetch1 to fetch2 record
    typedef struct packed {
        logic valid;
        u32_t pc;
        u32_t btb_pre;     // predicted next pc
        logic is_pred;
    } fetch_pass_t;

    // translation mode bits of crmd
    typedef struct packed {
        logic       da;
        logic       pg;
        logic [1:0] datf;  // mat used in direct mode
    } crmd_t;

    // direct-mapped window
    typedef struct packed {
        logic       plv0;
        logic       plv3;
        logic [1:0] mat;
        logic [2:0] pseg;
        logic [2:0] vseg;
    } dmw_t;

    // one tlb entry, 4 KiB pages only
    typedef struct packed {
        logic        e;
        logic [18:0] vppn;
        logic [19:0] ppn;
        logic        v;
        logic [1:0]  mat;
    } tlb_entry_t;

    localparam u32_t RESET_PC = 32'h1c000000;

endpackage

`default_nettype wire

/* verilog.f */
src/fetch_pkg.sv
src/btb_if.sv
src/btb.sv
src/addr_trans.sv
src/fetch1.sv
src/fetch_front.sv
sim/tb_clock.sv
sim/tb_fetch_front.sv
